/* design/maxpool_macros.svh */
// build-time sizing only; MP_POOL_SIZE and MP_MEMBERS must be at least 1, user indices 0 or 1.
`ifndef MAXPOOL_MACROS_SVH
`define MAXPOOL_MACROS_SVH

// core array shape.
`define MP_UNITS        2
`define MP_GROUPS       2

// output beats per frame, m_last closes each frame.
`define MP_MEMBERS      8

// signed data word.
`define MP_WORD_WIDTH   8

// non-bypass beats per pooling window.
`define MP_POOL_SIZE    4

// bit positions inside the two-bit beat tag.
`define MP_IDX_NOT_MAX  0
`define MP_IDX_MAX      1

// words per beat, two channels for every unit of every core.
`define MP_LANES        (`MP_GROUPS * `MP_UNITS * 2)

`endif

/* design/maxpool_pkg.sv */
// types only; every width follows the macros, so the header must be on the include path.
`include "maxpool_macros.svh"

package maxpool_pkg;

  // one signed data word, compares as signed.
  typedef logic signed [`MP_WORD_WIDTH-1:0] word_t;

  // beat tag, bit positions given by MP_IDX_NOT_MAX and MP_IDX_MAX.
  typedef logic [1:0] user_t;

  typedef logic [$clog2(`MP_POOL_SIZE + 1)-1:0] beat_cnt_t;  // position within a window.
  typedef logic [$clog2(`MP_MEMBERS + 1)-1:0]   out_cnt_t;   // output beats in a frame.

  // window controller, empty window or partly filled window.
  typedef enum logic {
    WIN_IDLE,
    WIN_ACC
  } win_state_t;

endpackage

/* design/maxpool_window_ctrl.sv */
// tag is combinational from window state, beat count and s_bypass; bypass beats never advance it.
`include "maxpool_macros.svh"

module maxpool_window_ctrl (
  input  logic               clk,
  input  logic               clken,
  input  logic               arst_n,
  input  logic               s_valid,
  input  logic               s_ready,
  input  logic               s_bypass,
  output maxpool_pkg::user_t user
);

  localparam maxpool_pkg::beat_cnt_t CNT_LAST = maxpool_pkg::beat_cnt_t'(`MP_POOL_SIZE - 1);

  maxpool_pkg::win_state_t state;
  maxpool_pkg::beat_cnt_t  cnt;
  logic                    accept;
  logic                    last_beat;

  assign accept    = clken && s_valid && s_ready;
  // an idle window has no count yet, only a one-beat window closes at once.
  assign last_beat = (state == maxpool_pkg::WIN_ACC) ? (cnt == CNT_LAST) : (`MP_POOL_SIZE == 1);

  always_comb begin
    user                  = '0;
    user[`MP_IDX_NOT_MAX] = s_bypass;
    user[`MP_IDX_MAX]     = !s_bypass && last_beat;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= maxpool_pkg::WIN_IDLE;
      cnt   <= '0;
    end else if (accept && !s_bypass) begin
      if (last_beat) begin
        state <= maxpool_pkg::WIN_IDLE;  // window closed, next beat starts a new one.
      end else begin
        case (state)
          maxpool_pkg::WIN_IDLE: begin
            state <= maxpool_pkg::WIN_ACC;
            cnt   <= maxpool_pkg::beat_cnt_t'(1);  // first beat of the window taken.
          end
          maxpool_pkg::WIN_ACC: begin
            cnt <= cnt + 1'b1;
          end
          default: begin
            state <= maxpool_pkg::WIN_IDLE;
            cnt   <= '0;
          end
        endcase
      end
    end
  end

endmodule

/* design/maxpool_core.sv */
// one core of MP_UNITS units; no output ready, stalls only through clken; latency is 1 cycle.
`include "maxpool_macros.svh"

module maxpool_core (
  input  logic               clk,
  input  logic               clken,
  input  logic               arst_n,
  input  logic               s_valid,
  input  maxpool_pkg::user_t s_user,
  input  maxpool_pkg::word_t s_data_uc [`MP_UNITS-1:0][1:0],
  output logic               s_ready,
  output logic               m_valid,
  output maxpool_pkg::word_t m_data_uc [`MP_UNITS-1:0][1:0],
  output logic               m_keep_uc [`MP_UNITS-1:0][1:0],
  output logic               m_last
);

  localparam maxpool_pkg::out_cnt_t OUT_LAST = maxpool_pkg::out_cnt_t'(`MP_MEMBERS - 1);

  maxpool_pkg::word_t    run_max  [`MP_UNITS-1:0][1:0];  // running maximum per lane.
  maxpool_pkg::word_t    beat_max [`MP_UNITS-1:0][1:0];  // maximum including this beat.
  maxpool_pkg::out_cnt_t out_cnt;
  logic                  accept;
  logic                  is_bypass;
  logic                  is_max;
  logic                  emit;
  logic                  fresh;                         // next pooled beat opens a window.

  assign accept    = clken && s_valid && s_ready;
  assign is_bypass = s_user[`MP_IDX_NOT_MAX];
  assign is_max    = s_user[`MP_IDX_MAX] && !is_bypass;
  assign emit      = accept && (is_bypass || is_max);

  // first beat loads, later beats compare signed against the running value.
  always_comb begin
    for (int u = 0; u < `MP_UNITS; u++) begin
      for (int c = 0; c < 2; c++) begin
        if (fresh || (s_data_uc[u][c] > run_max[u][c])) begin
          beat_max[u][c] = s_data_uc[u][c];
        end else begin
          beat_max[u][c] = run_max[u][c];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept && !is_bypass) begin
      run_max <= beat_max;  // bypass beats leave the window untouched.
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fresh <= 1'b1;
    end else if (accept && !is_bypass) begin
      fresh <= is_max;  // a max beat closes the window.
    end
  end

  // output payload, loaded only when a beat leaves.
  always_ff @(posedge clk) begin
    if (emit) begin
      for (int u = 0; u < `MP_UNITS; u++) begin
        for (int c = 0; c < 2; c++) begin
          m_data_uc[u][c] <= is_bypass ? s_data_uc[u][c] : beat_max[u][c];
          m_keep_uc[u][c] <= !is_bypass || (c == 0);  // bypass keeps channel 0 only.
        end
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s_ready <= 1'b0;
      m_valid <= 1'b0;
      m_last  <= 1'b0;
      out_cnt <= '0;
    end else if (clken) begin
      s_ready <= 1'b1;  // ready from the second cycle out of reset.
      m_valid <= emit;
      m_last  <= emit && (out_cnt == OUT_LAST);
      if (emit) begin
        if (out_cnt == OUT_LAST) begin
          out_cnt <= '0;  // frame done.
        end else begin
          out_cnt <= out_cnt + 1'b1;
        end
      end
    end
  end

endmodule

/* design/maxpool_engine.sv */
// ports are flat c-g-u with lane 0 in the low bits; all cores share one timing, core 0 speaks.
`include "maxpool_macros.svh"

module maxpool_engine (
  input  logic                                   clk,
  input  logic                                   clken,
  input  logic                                   arst_n,
  input  logic                                   s_valid,
  input  maxpool_pkg::user_t                     s_user,
  input  logic [`MP_LANES*`MP_WORD_WIDTH-1:0]    s_data_flat_cgu,
  output logic                                   s_ready,
  output logic                                   m_valid,
  output logic [`MP_LANES*`MP_WORD_WIDTH-1:0]    m_data_flat_cgu,
  output logic [`MP_LANES-1:0]                   m_keep_flat_cgu,
  output logic                                   m_last
);

  // g-u-c order used inside the cores.
  maxpool_pkg::word_t s_data_guc [`MP_GROUPS-1:0][`MP_UNITS-1:0][1:0];
  maxpool_pkg::word_t m_data_guc [`MP_GROUPS-1:0][`MP_UNITS-1:0][1:0];
  logic               m_keep_guc [`MP_GROUPS-1:0][`MP_UNITS-1:0][1:0];

  logic s_ready_core [`MP_GROUPS];
  logic m_valid_core [`MP_GROUPS];
  logic m_last_core  [`MP_GROUPS];

  // channel is the slowest index on the ports, so bypass keep bits fill from lane 0.
  for (genvar c = 0; c < 2; c++) begin : g_chan
    for (genvar g = 0; g < `MP_GROUPS; g++) begin : g_group
      for (genvar u = 0; u < `MP_UNITS; u++) begin : g_unit
        localparam int LANE = c * `MP_GROUPS * `MP_UNITS + g * `MP_UNITS + u;

        assign s_data_guc[g][u][c] =
          s_data_flat_cgu[LANE*`MP_WORD_WIDTH +: `MP_WORD_WIDTH];

        assign m_data_flat_cgu[LANE*`MP_WORD_WIDTH +: `MP_WORD_WIDTH] =
          m_data_guc[g][u][c];

        assign m_keep_flat_cgu[LANE] = m_keep_guc[g][u][c];
      end
    end
  end

  for (genvar i = 0; i < `MP_GROUPS; i++) begin : g_core
    maxpool_core core_i (
      .clk       (clk),
      .clken     (clken),
      .arst_n    (arst_n),
      .s_valid   (s_valid),
      .s_user    (s_user),
      .s_data_uc (s_data_guc[i]),
      .s_ready   (s_ready_core[i]),
      .m_valid   (m_valid_core[i]),
      .m_data_uc (m_data_guc[i]),
      .m_keep_uc (m_keep_guc[i]),
      .m_last    (m_last_core[i])
    );
  end

  // handshake from core 0, the rest run in lockstep.
  assign s_ready = s_ready_core[0];
  assign m_valid = m_valid_core[0];
  assign m_last  = m_last_core[0];

endmodule

/* design/maxpool_top.sv */
// no output ready; hold clken low to stall, every register then keeps its value.
`include "maxpool_macros.svh"

module maxpool_top (
  input  logic                                clk,
  input  logic                                clken,
  input  logic                                arst_n,
  input  logic                                s_valid,
  input  logic                                s_bypass,
  input  logic [`MP_LANES*`MP_WORD_WIDTH-1:0] s_data_flat_cgu,
  output logic                                s_ready,
  output logic                                m_valid,
  output logic [`MP_LANES*`MP_WORD_WIDTH-1:0] m_data_flat_cgu,
  output logic [`MP_LANES-1:0]                m_keep_flat_cgu,
  output logic                                m_last
);

  maxpool_pkg::user_t user;  // beat tag from the window controller.

  maxpool_window_ctrl window_ctrl_i (
    .clk      (clk),
    .clken    (clken),
    .arst_n   (arst_n),
    .s_valid  (s_valid),
    .s_ready  (s_ready),
    .s_bypass (s_bypass),
    .user     (user)
  );

  maxpool_engine engine_i (
    .clk             (clk),
    .clken           (clken),
    .arst_n          (arst_n),
    .s_valid         (s_valid),
    .s_user          (user),
    .s_data_flat_cgu (s_data_flat_cgu),
    .s_ready         (s_ready),
    .m_valid         (m_valid),
    .m_data_flat_cgu (m_data_flat_cgu),
    .m_keep_flat_cgu (m_keep_flat_cgu),
    .m_last          (m_last)
  );

endmodule

/* test/tb_clock.sv */
// free-running testbench clock with an 8 ns period and no enable; it starts low at time zero.
module tb_clock (
  output logic clk
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD = 4;  // in ns.

  initial begin
    clk = 1'b0;
  end

  always begin
    #HALF_PERIOD clk = ~clk;
  end

endmodule

/* test/maxpool_assert.sv */
// reference model updates on the rising edge; every check is sampled on the falling edge.
`include "maxpool_macros.svh"

module maxpool_assert (
  input logic                                clk,
  input logic                                clken,
  input logic                                arst_n,
  input logic                                s_valid,
  input logic                                s_bypass,
  input logic [`MP_LANES*`MP_WORD_WIDTH-1:0] s_data_flat_cgu,
  input logic                                s_ready,
  input logic                                m_valid,
  input logic [`MP_LANES*`MP_WORD_WIDTH-1:0] m_data_flat_cgu,
  input logic [`MP_LANES-1:0]                m_keep_flat_cgu,
  input logic                                m_last
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int W     = `MP_WORD_WIDTH;
  localparam int LANES = `MP_LANES;
  localparam int HALF  = LANES / 2;  // lanes below this are channel 0.
  localparam int OUT_W = LANES * W + LANES + 2;

  maxpool_pkg::word_t in_word [LANES];
  maxpool_pkg::word_t pooled  [LANES];  // window maximum including the current beat.
  maxpool_pkg::word_t win_max [LANES];
  logic [LANES*W-1:0] exp_data;
  logic [LANES-1:0]   exp_keep;
  logic [OUT_W-1:0]   out_now;
  logic [OUT_W-1:0]   out_before;     // outputs just before the last rising edge.
  int                 win_cnt;
  int                 frame_cnt;
  logic               exp_ready;
  logic               exp_valid;
  logic               exp_last;
  logic               held_cycle;     // last rising edge had clken low.
  logic               take;
  logic               closing;
  logic               emit;
  logic               fail_ready = 1'b0;
  logic               fail_valid = 1'b0;
  logic               fail_last  = 1'b0;
  logic               fail_data  = 1'b0;
  logic               fail_keep  = 1'b0;
  logic               fail_hold  = 1'b0;
  logic               fail_seen;

  assign take      = clken && s_valid && exp_ready;
  assign closing   = !s_bypass && (win_cnt == `MP_POOL_SIZE - 1);
  assign emit      = take && (s_bypass || closing);
  assign out_now   = {m_valid, m_last, m_keep_flat_cgu, m_data_flat_cgu};
  assign fail_seen = fail_ready | fail_valid | fail_last | fail_data | fail_keep | fail_hold;

  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      in_word[l] = maxpool_pkg::word_t'(s_data_flat_cgu[l*W +: W]);
      if (win_cnt == 0 || in_word[l] > win_max[l]) begin
        pooled[l] = in_word[l];  // signed compare.
      end else begin
        pooled[l] = win_max[l];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      exp_ready  <= 1'b0;
      exp_valid  <= 1'b0;
      exp_last   <= 1'b0;
      held_cycle <= 1'b0;
      win_cnt    <= 0;
      frame_cnt  <= 0;
      out_before <= '0;
    end else begin
      held_cycle <= !clken;
      out_before <= out_now;
      if (clken) begin
        exp_ready <= 1'b1;
        exp_valid <= emit;
        exp_last  <= emit && (frame_cnt == `MP_MEMBERS - 1);
      end
      if (emit) begin
        frame_cnt <= (frame_cnt == `MP_MEMBERS - 1) ? 0 : frame_cnt + 1;
        for (int l = 0; l < LANES; l++) begin
          exp_data[l*W +: W] <= s_bypass ? in_word[l] : pooled[l];
          exp_keep[l]        <= !s_bypass || (l < HALF);
        end
      end
      if (take && !s_bypass) begin
        win_cnt <= closing ? 0 : win_cnt + 1;
        win_max <= pooled;  // bypass beats leave the window alone.
      end
    end
  end

  a_ready: assert property (@(negedge clk) s_ready == exp_ready)
    else begin
      fail_ready = 1'b1;
      $error("MISMATCH s_ready got %h expected %h", s_ready, exp_ready);
    end

  a_valid: assert property (@(negedge clk) m_valid == exp_valid)
    else begin
      fail_valid = 1'b1;
      $error("MISMATCH m_valid got %h expected %h", m_valid, exp_valid);
    end

  a_last: assert property (@(negedge clk) m_last == exp_last)
    else begin
      fail_last = 1'b1;
      $error("MISMATCH m_last got %h expected %h", m_last, exp_last);
    end

  a_data: assert property (@(negedge clk) m_valid |-> (m_data_flat_cgu == exp_data))
    else begin
      fail_data = 1'b1;
      $error("MISMATCH m_data_flat_cgu got %h expected %h", m_data_flat_cgu, exp_data);
    end

  a_keep: assert property (@(negedge clk) m_valid |-> (m_keep_flat_cgu == exp_keep))
    else begin
      fail_keep = 1'b1;
      $error("MISMATCH m_keep_flat_cgu got %h expected %h", m_keep_flat_cgu, exp_keep);
    end

  // valid, last, keep and data must not move across a disabled edge.
  a_hold: assert property (@(negedge clk) held_cycle |-> (out_now == out_before))
    else begin
      fail_hold = 1'b1;
      $error("MISMATCH held outputs got %h expected %h", out_now, out_before);
    end

endmodule

bind maxpool_top maxpool_assert maxpool_assert_i (
  .clk             (clk),
  .clken           (clken),
  .arst_n          (arst_n),
  .s_valid         (s_valid),
  .s_bypass        (s_bypass),
  .s_data_flat_cgu (s_data_flat_cgu),
  .s_ready         (s_ready),
  .m_valid         (m_valid),
  .m_data_flat_cgu (m_data_flat_cgu),
  .m_keep_flat_cgu (m_keep_flat_cgu),
  .m_last          (m_last)
);

/* test/maxpool_tb.sv */
// random stimulus only, the bound maxpool_assert does all checking; run length is NUM_BEATS cycles.
`include "maxpool_macros.svh"

module maxpool_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int W           = `MP_WORD_WIDTH;
  localparam int LANES       = `MP_LANES;
  localparam int NUM_BEATS   = 600;
  localparam int WATCHDOG_NS = NUM_BEATS * 8 * 4;  // beats times period, four times over.

  logic               clk;
  logic               clken;
  logic               arst_n;
  logic               s_valid;
  logic               s_bypass;
  logic [LANES*W-1:0] s_data_flat_cgu;
  logic               s_ready;
  logic               m_valid;
  logic [LANES*W-1:0] m_data_flat_cgu;
  logic [LANES-1:0]   m_keep_flat_cgu;
  logic               m_last;
  integer             seed = 32'h3dca651d;

  tb_clock clock_i (
    .clk (clk)
  );

  maxpool_top maxpool_top_i (
    .clk             (clk),
    .clken           (clken),
    .arst_n          (arst_n),
    .s_valid         (s_valid),
    .s_bypass        (s_bypass),
    .s_data_flat_cgu (s_data_flat_cgu),
    .s_ready         (s_ready),
    .m_valid         (m_valid),
    .m_data_flat_cgu (m_data_flat_cgu),
    .m_keep_flat_cgu (m_keep_flat_cgu),
    .m_last          (m_last)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  function automatic logic [LANES*W-1:0] random_beat();
    logic [LANES*W-1:0] beat;
    for (int l = 0; l < LANES; l++) begin
      beat[l*W +: W] = maxpool_pkg::word_t'($random(seed));
    end
    return beat;
  endfunction

  initial begin : stimulus
    clken           = 1'b1;
    arst_n          = 1'b0;
    s_valid         = 1'b0;
    s_bypass        = 1'b0;
    s_data_flat_cgu = '0;
    repeat (3) @(negedge clk);
    arst_n = 1'b1;
    for (int i = 0; i < NUM_BEATS; i++) begin
      @(negedge clk);
      clken           = (($random(seed) & 7) != 0);     // low about one cycle in eight.
      s_valid         = (($random(seed) & 15) != 0);
      s_bypass        = (($random(seed) & 255) < 51);   // about 20 percent.
      s_data_flat_cgu = random_beat();
    end
    @(negedge clk);
    clken   = 1'b1;
    s_valid = 1'b0;
    repeat (4) @(negedge clk);
    @(posedge clk);  // away from the falling edge where the checks sample.
    if (maxpool_top_i.maxpool_assert_i.fail_seen) begin
      abort_run("checker reported an error during the run");
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

  initial begin : fail_watch
    wait (maxpool_top_i.maxpool_assert_i.fail_seen);
    abort_run("checker assertion failed, see the MISMATCH line above");
  end

  initial begin : watchdog
    #WATCHDOG_NS;
    abort_run("watchdog expired before the stimulus finished");
  end

endmodule

/* compile.f */
+incdir+design
design/maxpool_pkg.sv
design/maxpool_window_ctrl.sv
design/maxpool_core.sv
design/maxpool_engine.sv
design/maxpool_top.sv
test/tb_clock.sv
test/maxpool_assert.sv
test/maxpool_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the maxpool testbench with Verilator, runs it and checks the log for the pass line.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f compile.f --top-module maxpool_tb -o maxpool_sim \
  && ./obj_dir/maxpool_sim +verilator+error+limit+100 > sim.log 2>&1

grep -q "TEST RESULT: PASS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
